//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_io_subsystem
FILELIST = compile.f
OBJDIR   = obj_dir
SIM_ARGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJDIR)

//--- compile.f
io_map_pkg.sv
io_bus_pkg.sv
io_address_decoder.sv
io_access_splitter.sv
io_request_fifo.sv
io_target_bank.sv
io_subsystem_top.sv
io_subsystem_chk.sv
tb_io_subsystem.sv

//--- io_access_splitter.sv
// Host access splitter
`timescale 1ns/100ps

module io_access_splitter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  io_bus_pkg::host_cmd_t  cmd,
    input  logic                   cmd_req,
    output logic                   cmd_ack,
    input  logic                   full,
    output logic                   push,
    output io_bus_pkg::bus_cycle_t push_cycle
);

    typedef enum logic [1:0] {
        idle,
        first,
        second,
        done
    } split_state_e;

    split_state_e state;
    split_state_e state_nxt;

    // Odd port word access needs two byte cycles
    logic                  odd_port;
    logic                  split;
    io_bus_pkg::io_waddr_t base_waddr;

    assign odd_port   = cmd.port[0];
    assign split      = cmd.is_word && odd_port;
    assign base_waddr = cmd.port[15:1];

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (cmd_req) state_nxt = first;
            end
            first: begin
                // Stall here while the FIFO is full
                if (!full) state_nxt = split ? second : done;
            end
            second: begin
                if (!full) state_nxt = done;
            end
            done: begin
                // Four-phase return to zero
                if (!cmd_req) state_nxt = idle;
            end
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end
        else begin
            state <= state_nxt;
        end
    end

    // Ack follows the last push by one cycle
    assign cmd_ack = (state == done);
    assign push    = ((state == first) || (state == second)) && !full;

    // Cycle contents by the split rule
    always_comb begin
        push_cycle.is_write = cmd.is_write;
        if (state == second) begin
            // Upper half of an odd word, next word address, low lane
            push_cycle.waddr = base_waddr + 15'd1;
            push_cycle.be    = 2'b01;
            push_cycle.wdata = {8'h00, cmd.wdata[15:8]};
        end
        else if (odd_port) begin
            // Odd byte, or first half of an odd word, high lane
            push_cycle.waddr = base_waddr;
            push_cycle.be    = 2'b10;
            push_cycle.wdata = {cmd.wdata[7:0], 8'h00};
        end
        else if (cmd.is_word) begin
            push_cycle.waddr = base_waddr;
            push_cycle.be    = 2'b11;
            push_cycle.wdata = cmd.wdata;
        end
        else begin
            // Even byte on the low lane
            push_cycle.waddr = base_waddr;
            push_cycle.be    = 2'b01;
            push_cycle.wdata = {8'h00, cmd.wdata[7:0]};
        end
    end

endmodule

//--- io_address_decoder.sv
// I/O port address decoder
`timescale 1ns/100ps

module io_address_decoder (
    input  io_bus_pkg::io_waddr_t  waddr,
    output io_map_pkg::io_device_e device
);

    // Even byte port of the addressed word
    io_bus_pkg::io_port_t port;

    // True when p lies in [base, base + size)
    // Wrapping subtract keeps windows at the top of the map correct
    function automatic logic in_window(
        input io_bus_pkg::io_port_t p,
        input logic [15:0]          base,
        input logic [15:0]          size
    );
        io_bus_pkg::io_port_t offset;
        offset = p - base;
        return offset < size;
    endfunction

    assign port = {waddr, 1'b0};

    // Priority order follows the PC/XT decoder, first match wins
    always_comb begin
        if (in_window(port, io_map_pkg::VGA_BASE, io_map_pkg::VGA_SIZE)) begin
            // 3C0h to 3DFh register block
            device = io_map_pkg::dev_vga;
        end
        else if (in_window(port, io_map_pkg::LEDS_BASE, io_map_pkg::LEDS_SIZE)) begin
            device = io_map_pkg::dev_leds;
        end
        else if (in_window(port, io_map_pkg::SDRAM_CFG_BASE, io_map_pkg::SDRAM_CFG_SIZE)) begin
            device = io_map_pkg::dev_sdram_cfg;
        end
        else if (in_window(port, io_map_pkg::UART_BASE, io_map_pkg::UART_SIZE)) begin
            device = io_map_pkg::dev_uart;
        end
        else if (in_window(port, io_map_pkg::IRQ_CTRL_BASE, io_map_pkg::IRQ_CTRL_SIZE)) begin
            device = io_map_pkg::dev_irq_ctrl;
        end
        else if (in_window(port, io_map_pkg::BIOS_CTRL_BASE, io_map_pkg::BIOS_CTRL_SIZE)) begin
            device = io_map_pkg::dev_bios_ctrl;
        end
        else if (in_window(port, io_map_pkg::TIMER_BASE, io_map_pkg::TIMER_SIZE)) begin
            // 8253 PIT
            device = io_map_pkg::dev_timer;
        end
        else if (in_window(port, io_map_pkg::PIC_BASE, io_map_pkg::PIC_SIZE)) begin
            // 8259 PIC
            device = io_map_pkg::dev_pic;
        end
        else if (in_window(port, io_map_pkg::PS2_MOUSE_BASE, io_map_pkg::PS2_MOUSE_SIZE)) begin
            device = io_map_pkg::dev_ps2_mouse;
        end
        else if (in_window(port, io_map_pkg::PS2_KBD_BASE,
                           io_map_pkg::PS2_KBD_SIZE + io_map_pkg::PPI_SIZE)) begin
            // 8255 block, port A is the keyboard buffer
            if (in_window(port, io_map_pkg::PS2_KBD_BASE, io_map_pkg::PS2_KBD_SIZE)) begin
                device = io_map_pkg::dev_ps2_kbd;
            end
            else begin
                device = io_map_pkg::dev_ppi;
            end
        end
        else begin
            // Nothing claims the port
            device = io_map_pkg::dev_default;
        end
    end

endmodule

//--- io_bus_pkg.sv
// I/O bus types
package io_bus_pkg;

    // Byte port address and its word form (port bits 15:1)
    typedef logic [15:0] io_port_t;
    typedef logic [14:0] io_waddr_t;

    // Data word and byte enables, bit 0 is the even lane
    typedef logic [15:0] io_data_t;
    typedef logic [1:0]  io_be_t;

    // Host command, held stable while cmd_req is high
    typedef struct packed {
        io_port_t port;
        io_data_t wdata;
        logic     is_write;
        logic     is_word;
    } host_cmd_t;

    // One 16-bit bus cycle as queued in the request FIFO
    typedef struct packed {
        io_waddr_t waddr;
        io_be_t    be;
        io_data_t  wdata;
        logic      is_write;
    } bus_cycle_t;

    // Read response, disabled lanes are zero
    typedef struct packed {
        io_map_pkg::io_device_e device;
        io_be_t                 be;
        io_data_t               rdata;
    } io_resp_t;

    // Request FIFO geometry
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;

endpackage

//--- io_map_pkg.sv
// I/O port map
package io_map_pkg;

    // Device select, one code per decoded window
    typedef enum logic [3:0] {
        dev_default,
        dev_vga,
        dev_leds,
        dev_sdram_cfg,
        dev_uart,
        dev_irq_ctrl,
        dev_bios_ctrl,
        dev_timer,
        dev_pic,
        dev_ps2_mouse,
        dev_ps2_kbd,
        dev_ppi
    } io_device_e;

    // Window base ports, PC/XT layout plus the SoC control ports at the top
    localparam logic [15:0] VGA_BASE       = 16'h03C0;
    localparam logic [15:0] LEDS_BASE      = 16'hFFFE;
    localparam logic [15:0] SDRAM_CFG_BASE = 16'hFFFC;
    localparam logic [15:0] UART_BASE      = 16'hFFFA;
    localparam logic [15:0] IRQ_CTRL_BASE  = 16'hFFF6;
    localparam logic [15:0] BIOS_CTRL_BASE = 16'hFFEC;
    localparam logic [15:0] TIMER_BASE     = 16'h0040;
    localparam logic [15:0] PIC_BASE       = 16'h0020;
    localparam logic [15:0] PS2_MOUSE_BASE = 16'hFFE0;
    localparam logic [15:0] PS2_KBD_BASE   = 16'h0060;
    localparam logic [15:0] PPI_BASE       = 16'h0062;

    // Window sizes in bytes
    localparam logic [15:0] VGA_SIZE       = 16'd32;
    localparam logic [15:0] LEDS_SIZE      = 16'd2;
    localparam logic [15:0] SDRAM_CFG_SIZE = 16'd2;
    localparam logic [15:0] UART_SIZE      = 16'd2;
    localparam logic [15:0] IRQ_CTRL_SIZE  = 16'd2;
    localparam logic [15:0] BIOS_CTRL_SIZE = 16'd2;
    localparam logic [15:0] TIMER_SIZE     = 16'd8;
    localparam logic [15:0] PIC_SIZE       = 16'd4;
    localparam logic [15:0] PS2_MOUSE_SIZE = 16'd2;
    localparam logic [15:0] PS2_KBD_SIZE   = 16'd2;
    localparam logic [15:0] PPI_SIZE       = 16'd6;

    // Floating bus value seen on unmapped ports
    localparam logic [15:0] OPEN_BUS_DATA  = 16'hFFFF;

endpackage

//--- io_request_fifo.sv
// Bus cycle request FIFO
`timescale 1ns/100ps

module io_request_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  io_bus_pkg::bus_cycle_t push_cycle,
    output logic                   full,
    input  logic                   pop,
    output io_bus_pkg::bus_cycle_t head,
    output logic                   not_empty
);

    // Entry storage
    io_bus_pkg::bus_cycle_t mem [io_bus_pkg::FIFO_DEPTH];

    logic [io_bus_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [io_bus_pkg::FIFO_PTR_W-1:0] rd_ptr;
    // One extra bit so a full queue is distinct from empty
    logic [io_bus_pkg::FIFO_PTR_W:0]   count;

    logic do_push;
    logic do_pop;

    assign full      = (count == (io_bus_pkg::FIFO_PTR_W + 1)'(io_bus_pkg::FIFO_DEPTH));
    assign not_empty = (count != '0);

    // Qualified strobes
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    // Head is the oldest entry
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cycle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- io_subsystem_chk.sv
// I/O subsystem handshake assertions
`timescale 1ns/100ps

module io_subsystem_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 cmd_req,
    input logic                 cmd_ack,
    input logic                 push,
    input logic                 pop,
    input logic                 resp_req,
    input logic                 resp_ack,
    input io_bus_pkg::io_resp_t resp
);

    // Failed assertion tally, read by the testbench
    int fail_count = 0;

    // Buffer occupancy rebuilt from the push and pop strobes
    logic [io_bus_pkg::FIFO_PTR_W:0] level;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level <= '0;
        end
        else begin
            level <= level + (io_bus_pkg::FIFO_PTR_W + 1)'(push)
                           - (io_bus_pkg::FIFO_PTR_W + 1)'(pop);
        end
    end

    // Ack answers a pending command only
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req)
        else begin
            $error("cmd_ack rose while cmd_req was low");
            fail_count++;
        end

    // Response held until acknowledged
    resp_held: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_req && !resp_ack) |=> (!resp_req || $stable(resp)))
        else begin
            $error("resp changed while resp_req was waiting for resp_ack");
            fail_count++;
        end

    // A push only lands while the buffer has a free entry
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (level < (io_bus_pkg::FIFO_PTR_W + 1)'(io_bus_pkg::FIFO_DEPTH)))
        else begin
            $error("Splitter pushed into a full FIFO");
            fail_count++;
        end

    // Reset clears the response request
    reset_clears_req: assert property (@(posedge clk) !rst_n |=> !resp_req)
        else begin
            $error("resp_req high after reset");
            fail_count++;
        end

endmodule

bind io_subsystem_top io_subsystem_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .push     (push),
    .pop      (pop),
    .resp_req (resp_req),
    .resp_ack (resp_ack),
    .resp     (resp)
);

//--- io_subsystem_top.sv
// I/O subsystem top
`timescale 1ns/100ps

module io_subsystem_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  io_bus_pkg::host_cmd_t cmd,
    input  logic                  cmd_req,
    output logic                  cmd_ack,
    output io_bus_pkg::io_resp_t  resp,
    output logic                  resp_req,
    input  logic                  resp_ack
);

    // Splitter to FIFO
    logic                   push;
    logic                   full;
    io_bus_pkg::bus_cycle_t push_cycle;

    // FIFO to bank
    logic                   pop;
    logic                   not_empty;
    io_bus_pkg::bus_cycle_t head;

    io_access_splitter u_splitter (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_req    (cmd_req),
        .cmd_ack    (cmd_ack),
        .full       (full),
        .push       (push),
        .push_cycle (push_cycle)
    );

    io_request_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_cycle (push_cycle),
        .full       (full),
        .pop        (pop),
        .head       (head),
        .not_empty  (not_empty)
    );

    io_target_bank u_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .not_empty  (not_empty),
        .head       (head),
        .pop        (pop),
        .resp       (resp),
        .resp_req   (resp_req),
        .resp_ack   (resp_ack)
    );

endmodule

//--- io_target_bank.sv
// I/O target register bank
`timescale 1ns/100ps

module io_target_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   not_empty,
    input  io_bus_pkg::bus_cycle_t head,
    output logic                   pop,
    output io_bus_pkg::io_resp_t   resp,
    output logic                   resp_req,
    input  logic                   resp_ack
);

    typedef enum logic [1:0] {
        ready,
        respond,
        wait_low
    } bank_state_e;

    bank_state_e state;

    // Four scratch words per mapped device, no storage for dev_default
    io_bus_pkg::io_data_t scratch [io_map_pkg::dev_vga:io_map_pkg::dev_ppi][4];

    io_map_pkg::io_device_e dev;
    logic [1:0]             sel;
    io_bus_pkg::io_data_t   rd_word;
    io_bus_pkg::io_data_t   lane_mask;
    logic                   wr_pop;
    logic                   rd_pop;

    io_address_decoder u_decoder (
        .waddr  (head.waddr),
        .device (dev)
    );

    // Word within the device from port bits 2:1
    assign sel = head.waddr[1:0];

    // Pop only while no response is outstanding
    assign pop    = (state == ready) && not_empty;
    assign wr_pop = pop && head.is_write;
    assign rd_pop = pop && !head.is_write;

    assign lane_mask = {{8{head.be[1]}}, {8{head.be[0]}}};
    assign resp_req  = (state == respond);

    // Selected word, open bus when unmapped
    always_comb begin
        rd_word = io_map_pkg::OPEN_BUS_DATA;
        for (int d = io_map_pkg::dev_vga; d <= io_map_pkg::dev_ppi; d++) begin
            if (dev == io_map_pkg::io_device_e'(d)) begin
                rd_word = scratch[d][sel];
            end
        end
    end

    // Scratch writes, enabled lanes only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int d = io_map_pkg::dev_vga; d <= io_map_pkg::dev_ppi; d++) begin
                for (int w = 0; w < 4; w++) begin
                    scratch[d][w] <= '0;
                end
            end
        end
        else if (wr_pop && (dev != io_map_pkg::dev_default)) begin
            if (head.be[0]) scratch[dev][sel][7:0]  <= head.wdata[7:0];
            if (head.be[1]) scratch[dev][sel][15:8] <= head.wdata[15:8];
        end
    end

    // Response captured in the pop cycle
    always_ff @(posedge clk) begin
        if (rd_pop) begin
            resp.device <= dev;
            resp.be     <= head.be;
            resp.rdata  <= rd_word & lane_mask;
        end
    end

    // Four-phase response handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ready;
        end
        else begin
            case (state)
                ready: begin
                    // Writes stay here and retire every cycle
                    if (rd_pop) state <= respond;
                end
                respond: begin
                    if (resp_ack) state <= wait_low;
                end
                wait_low: begin
                    if (!resp_ack) state <= ready;
                end
                default: state <= ready;
            endcase
        end
    end

endmodule

//--- tb_io_subsystem.sv
// I/O subsystem testbench
`timescale 1ns/100ps

module tb_io_subsystem;

    // Commands per test: decode 23, scratch 43, lanes 6, odd word 6, burst 16
    localparam int NUM_CMDS = 23 + 43 + 6 + 6 + 16;
    localparam int WATCHDOG_CYCLES = NUM_CMDS * 200 + 1000;

    // Window edges from the port map, in decoder priority order
    localparam logic [15:0] FIRST_PORT [11] = '{16'h03C0, 16'hFFFE, 16'hFFFC, 16'hFFFA,
        16'hFFF6, 16'hFFEC, 16'h0040, 16'h0020, 16'hFFE0, 16'h0060, 16'h0062};
    localparam logic [15:0] LAST_PORT [11] = '{16'h03DF, 16'hFFFF, 16'hFFFD, 16'hFFFB,
        16'hFFF7, 16'hFFED, 16'h0047, 16'h0023, 16'hFFE1, 16'h0061, 16'h0067};

    logic                  clk;
    logic                  rst_n;
    io_bus_pkg::host_cmd_t cmd;
    logic                  cmd_req;
    logic                  cmd_ack;
    io_bus_pkg::io_resp_t  resp;
    logic                  resp_req;
    logic                  resp_ack;

    int          errors = 0;
    int          checks = 0;
    int          ack_delay = 0;
    logic        use_lfsr = 1'b0;
    logic [15:0] lfsr_state = 16'd65;

    // Expected scratch words per device and pending read responses
    logic [15:0]          ref_mem [12][4];
    io_bus_pkg::io_resp_t exp_q [$];

    io_subsystem_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .resp     (resp),
        .resp_req (resp_req),
        .resp_ack (resp_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic int lfsr_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    // PC/XT port map on the even port of a word
    function automatic io_map_pkg::io_device_e port_device(input logic [15:0] p);
        logic [15:0] w;
        w = {p[15:1], 1'b0};
        if (w >= 16'h03C0 && w <= 16'h03DF) return io_map_pkg::dev_vga;
        if (w == 16'hFFFE) return io_map_pkg::dev_leds;
        if (w == 16'hFFFC) return io_map_pkg::dev_sdram_cfg;
        if (w == 16'hFFFA) return io_map_pkg::dev_uart;
        if (w == 16'hFFF6) return io_map_pkg::dev_irq_ctrl;
        if (w == 16'hFFEC) return io_map_pkg::dev_bios_ctrl;
        if (w >= 16'h0040 && w <= 16'h0047) return io_map_pkg::dev_timer;
        if (w >= 16'h0020 && w <= 16'h0023) return io_map_pkg::dev_pic;
        if (w == 16'hFFE0) return io_map_pkg::dev_ps2_mouse;
        if (w == 16'h0060) return io_map_pkg::dev_ps2_kbd;
        if (w >= 16'h0062 && w <= 16'h0067) return io_map_pkg::dev_ppi;
        return io_map_pkg::dev_default;
    endfunction

    // Reference effect of one bus cycle
    task automatic model_cycle(input logic [14:0] waddr, input logic [1:0] be,
                               input logic [15:0] wdata, input logic is_write);
        io_map_pkg::io_device_e d;
        io_bus_pkg::io_resp_t   r;
        logic [15:0]            mask;
        logic [15:0]            word;
        d    = port_device({waddr, 1'b0});
        mask = {{8{be[1]}}, {8{be[0]}}};
        word = (d == io_map_pkg::dev_default) ? 16'hFFFF : ref_mem[d][waddr[1:0]];
        if (is_write) begin
            // Unmapped writes vanish
            if (d != io_map_pkg::dev_default) ref_mem[d][waddr[1:0]] = (word & ~mask) | (wdata & mask);
        end
        else begin
            r.device = d;
            r.be     = be;
            r.rdata  = word & mask;
            exp_q.push_back(r);
        end
    endtask

    // One host command, modelled by the split rule, then the four-phase handshake
    task automatic host_access(input logic [15:0] port, input logic [15:0] data,
                               input logic is_write, input logic is_word);
        if (is_word && port[0]) begin
            model_cycle(port[15:1], 2'b10, {data[7:0], 8'h00}, is_write);
            model_cycle(port[15:1] + 15'd1, 2'b01, {8'h00, data[15:8]}, is_write);
        end
        else if (is_word) begin
            model_cycle(port[15:1], 2'b11, data, is_write);
        end
        else if (port[0]) begin
            model_cycle(port[15:1], 2'b10, {data[7:0], 8'h00}, is_write);
        end
        else begin
            model_cycle(port[15:1], 2'b01, {8'h00, data[7:0]}, is_write);
        end
        @(posedge clk);
        cmd     <= '{port: port, wdata: data, is_write: is_write, is_word: is_word};
        cmd_req <= 1'b1;
        do @(posedge clk); while (!cmd_ack);
        cmd_req <= 1'b0;
        do @(posedge clk); while (cmd_ack);
    endtask

    // Compare one response with the oldest expected read
    task automatic expect_read(input io_bus_pkg::io_resp_t got);
        io_bus_pkg::io_resp_t exp;
        if (exp_q.size() == 0) begin
            $display("Read response at %0t arrived with no read outstanding", $time);
            errors++;
        end
        else begin
            exp = exp_q.pop_front();
            checks += 3;
            if (got.device != exp.device) begin
                $display("ERROR %0t resp.device got %0d exp %0d", $time, got.device, exp.device);
                errors++;
            end
            if (got.be != exp.be) begin
                $display("ERROR %0t resp.be got %b exp %b", $time, got.be, exp.be);
                errors++;
            end
            if (got.rdata != exp.rdata) begin
                $display("ERROR %0t resp.rdata got %h exp %h", $time, got.rdata, exp.rdata);
                errors++;
            end
        end
    endtask

    // Response side, ack after a fixed or LFSR delay
    initial begin : response_model
        int delay;
        forever begin
            @(posedge clk);
            if (resp_req && !resp_ack) begin
                expect_read(resp);
                delay = use_lfsr ? lfsr_bits(4) : ack_delay;
                repeat (delay) @(posedge clk);
                resp_ack <= 1'b1;
                do @(posedge clk); while (resp_req);
                resp_ack <= 1'b0;
            end
        end
    end

    // Edges of every window plus one unmapped port
    task automatic decode_map_test();
        ack_delay = 2;
        for (int i = 0; i < 11; i++) begin
            host_access(FIRST_PORT[i], 16'h0000, 1'b0, 1'b0);
            host_access(LAST_PORT[i], 16'h0000, 1'b0, 1'b0);
        end
        host_access(16'h0100, 16'h0000, 1'b0, 1'b0);
    endtask

    // Every reachable word of each window, write or read
    task automatic sweep_words(input logic is_write);
        logic [15:0] p;
        for (int i = 0; i < 11; i++) begin
            for (int w = 0; w < 4; w++) begin
                p = FIRST_PORT[i] + 16'(2 * w);
                if (p >= FIRST_PORT[i] && p <= LAST_PORT[i]) host_access(p, p ^ 16'hA55A, is_write, 1'b1);
            end
        end
    endtask

    task automatic scratch_test();
        ack_delay = 0;
        sweep_words(1'b1);
        sweep_words(1'b0);
        host_access(16'h0100, 16'h1234, 1'b1, 1'b1);
        host_access(16'h0100, 16'h0000, 1'b0, 1'b1);
        host_access(16'h0101, 16'h0000, 1'b0, 1'b0);
    endtask

    task automatic byte_lane_test();
        ack_delay = 1;
        host_access(16'h0044, 16'hBEEF, 1'b1, 1'b1);
        host_access(16'h0044, 16'h0012, 1'b1, 1'b0);
        host_access(16'h0045, 16'h0034, 1'b1, 1'b0);
        host_access(16'h0044, 16'h0000, 1'b0, 1'b0);
        host_access(16'h0045, 16'h0000, 1'b0, 1'b0);
        host_access(16'h0044, 16'h0000, 1'b0, 1'b1);
    endtask

    // Odd words, one of them straddling keyboard and PPI
    task automatic odd_word_test();
        ack_delay = 3;
        host_access(16'h03C3, 16'hA1B2, 1'b1, 1'b1);
        host_access(16'h03C3, 16'h0000, 1'b0, 1'b0);
        host_access(16'h03C4, 16'h0000, 1'b0, 1'b0);
        host_access(16'h03C3, 16'h0000, 1'b0, 1'b1);
        host_access(16'h0061, 16'h7788, 1'b1, 1'b1);
        host_access(16'h0061, 16'h0000, 1'b0, 1'b1);
    endtask

    // Slow random acks fill the FIFO
    task automatic backpressure_test();
        use_lfsr = 1'b1;
        for (int i = 0; i < 16; i++) begin
            host_access(16'h03C0 + 16'(i * 3), 16'h0000, 1'b0, i[0]);
        end
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        cmd      = '0;
        cmd_req  = 1'b0;
        resp_ack = 1'b0;
        rst_n    = 1'b0;
        for (int d = 0; d < 12; d++) begin
            for (int w = 0; w < 4; w++) ref_mem[d][w] = 16'h0000;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        decode_map_test();
        scratch_test();
        byte_lane_test();
        odd_word_test();
        backpressure_test();
        // Drain the last responses
        while (exp_q.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk);
        errors += DUT.u_chk.fail_count;
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, DUT.u_chk.fail_count);
        if (errors == 0) begin
            $display("TB PASSED");
        end
        else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
